// File: rtl/frontend_pkg.sv
package frontend_pkg;

    // widths
    localparam int unsigned XLEN             = 32;
    localparam int unsigned BEAT_BITS        = 64;
    localparam int unsigned BEATS_PER_LINE   = 4;
    localparam int unsigned WORDS_PER_LINE   = 8;
    localparam int unsigned LINE_OFFSET_BITS = 5;   // 32-byte line

    typedef logic [XLEN-1:0]      addr_t;
    typedef logic [XLEN-1:0]      inst_t;
    typedef logic [BEAT_BITS-1:0] beat_t;
    typedef logic [4:0]           arch_reg_t;

    // RV32I base opcodes
    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011
    } opcode_e;

    // reservation station the instruction would be sent to
    typedef enum logic [2:0] {
        class_add  = 3'd0,
        class_mul  = 3'd1,
        class_div  = 3'd2,
        class_mem  = 3'd3,
        class_br   = 3'd4,
        class_none = 3'd5
    } inst_class_e;

    // line fetch sequencing
    typedef enum logic [1:0] {
        st_request = 2'd0,  // waiting to issue the line read
        st_burst   = 2'd1,  // collecting beats
        st_drain   = 2'd2   // pushing words into the queue
    } fetch_state_e;

endpackage : frontend_pkg

// File: rtl/iq_push_if.sv
`timescale 1ns/10ps

interface iq_push_if
import frontend_pkg::*;
();

    logic   push;
    inst_t  push_inst;
    addr_t  push_pc;
    logic   full;       // no room for another entry

    modport producer (
        output push,
        output push_inst,
        output push_pc,
        input  full
    );

    modport buffer_in (
        input  push,
        input  push_inst,
        input  push_pc,
        output full
    );

endinterface : iq_push_if

// File: rtl/iq_pop_if.sv
`timescale 1ns/10ps

interface iq_pop_if
import frontend_pkg::*;
();

    logic   empty;
    inst_t  head_inst;  // valid while empty is low
    addr_t  head_pc;
    logic   pop;

    modport buffer_out (
        output empty,
        output head_inst,
        output head_pc,
        input  pop
    );

    modport consumer (
        input  empty,
        input  head_inst,
        input  head_pc,
        output pop
    );

endinterface : iq_pop_if

// File: rtl/line_fetch.sv
`timescale 1ns/10ps

module line_fetch
import frontend_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h1eceb000
)
(
    input   logic           clk,
    input   logic           rst,

    input   logic           redirect_i,
    input   addr_t          redirect_pc_i,

    output  addr_t          bmem_addr_o,
    output  logic           bmem_read_o,
    input   logic           bmem_ready_i,
    input   addr_t          bmem_raddr_i,
    input   beat_t          bmem_rdata_i,
    input   logic           bmem_rvalid_i,

    iq_push_if.producer     iq
);

    localparam int unsigned BEAT_CNT_W = $clog2(BEATS_PER_LINE);
    localparam int unsigned WORD_IDX_W = LINE_OFFSET_BITS - 2;

    fetch_state_e                           state;
    addr_t                                  pc;
    addr_t                                  line_addr;  // line of the burst in flight
    logic   [WORDS_PER_LINE-1:0][XLEN-1:0]  line_words;
    logic   [BEAT_CNT_W-1:0]                beat_cnt;
    logic                                   discard;    // burst was cancelled by a redirect
    logic                                   started;
    logic                                   issue;
    logic                                   beat_ok;
    logic                                   last_beat;
    logic                                   line_end;
    logic   [WORD_IDX_W-1:0]                word_idx;

    assign word_idx = pc[LINE_OFFSET_BITS-1:2];
    assign line_end = (word_idx == WORD_IDX_W'(WORDS_PER_LINE - 1));

    // first request goes out one cycle after reset is released
    assign issue       = started && (state == st_request) && bmem_ready_i;
    assign bmem_read_o = issue;
    assign bmem_addr_o = {pc[XLEN-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

    // while discarding, every beat counts toward the end of the dead burst
    assign beat_ok = bmem_rvalid_i && (state == st_burst) &&
                     (discard ||
                      bmem_raddr_i[XLEN-1:LINE_OFFSET_BITS] ==
                      line_addr[XLEN-1:LINE_OFFSET_BITS]);
    assign last_beat = beat_ok && (beat_cnt == BEAT_CNT_W'(BEATS_PER_LINE - 1));

    // one word per cycle from the pc's offset to the end of the line
    assign iq.push      = (state == st_drain) && !iq.full;
    assign iq.push_inst = line_words[word_idx];
    assign iq.push_pc   = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_request;
            pc       <= RESET_PC;
            beat_cnt <= '0;
            discard  <= 1'b0;
            started  <= 1'b0;
        end else begin
            started <= 1'b1;

            unique case (state)
                st_request: begin
                    if (issue) begin
                        state    <= st_burst;
                        beat_cnt <= '0;
                        discard  <= redirect_i;     // redirect on the issue edge
                    end
                end
                st_burst: begin
                    if (beat_ok) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (redirect_i) begin
                        discard <= 1'b1;
                    end
                    if (last_beat) begin
                        discard <= 1'b0;
                        // a cancelled line is dropped and the new pc refetched
                        state   <= (discard || redirect_i) ? st_request : st_drain;
                    end
                end
                st_drain: begin
                    if (iq.push && line_end) begin
                        state <= st_request;
                    end
                end
                default: state <= st_request;
            endcase

            if (iq.push) begin
                pc <= pc + 32'd4;
            end

            if (redirect_i) begin
                pc <= redirect_pc_i;
                if (state == st_drain) begin
                    state <= st_request;    // rest of the line is stale
                end
            end
        end
    end

    // line buffer, beats arrive lowest address first
    always_ff @(posedge clk) begin
        if (issue) begin
            line_addr <= bmem_addr_o;
        end
        if (beat_ok) begin
            line_words <= {bmem_rdata_i, line_words[WORDS_PER_LINE-1:2]};
        end
    end

endmodule : line_fetch

// File: rtl/inst_queue.sv
`timescale 1ns/10ps

module inst_queue
import frontend_pkg::*;
#(
    parameter int unsigned IQ_DEPTH = 16
)
(
    input   logic           clk,
    input   logic           rst,
    input   logic           flush_i,

    iq_push_if.buffer_in    wr,
    iq_pop_if.buffer_out    rd
);

    localparam int unsigned PTR_W = $clog2(IQ_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    inst_t              inst_mem [IQ_DEPTH];
    addr_t              pc_mem   [IQ_DEPTH];

    logic   [PTR_W-1:0] wr_ptr;
    logic   [PTR_W-1:0] rd_ptr;
    logic   [CNT_W-1:0] count;      // entries held
    logic               do_push;
    logic               do_pop;

    assign wr.full  = (count == CNT_W'(IQ_DEPTH));
    assign rd.empty = (count == '0);

    assign do_push = wr.push && !wr.full;
    assign do_pop  = rd.pop && !rd.empty;

    // head is read straight out of the array
    assign rd.head_inst = inst_mem[rd_ptr];
    assign rd.head_pc   = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            unique case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[wr_ptr] <= wr.push_inst;
            pc_mem[wr_ptr]   <= wr.push_pc;
        end
    end

endmodule : inst_queue

// File: rtl/dispatch_decode.sv
`timescale 1ns/10ps

module dispatch_decode
import frontend_pkg::*;
(
    input   logic           clk,
    input   logic           rst,
    input   logic           flush_i,

    iq_pop_if.consumer      iq,

    output  logic           dispatch_valid_o,
    input   logic           dispatch_ready_i,
    output  addr_t          dispatch_pc_o,
    output  inst_t          dispatch_inst_o,
    output  inst_class_e    dispatch_class_o,
    output  arch_reg_t      dispatch_rd_o,
    output  arch_reg_t      dispatch_rs1_o,
    output  arch_reg_t      dispatch_rs2_o
);

    logic           valid_q;
    inst_class_e    head_class;
    arch_reg_t      head_rd;
    opcode_e        head_op;

    assign head_op = opcode_e'(iq.head_inst[6:0]);

    // sort by opcode into the reservation station class
    always_comb begin
        head_rd = iq.head_inst[11:7];
        unique case (head_op)
            op_b_jal, op_b_jalr: head_class = class_br;
            op_b_br: begin
                head_class = class_br;
                head_rd    = '0;            // no destination
            end
            op_b_load:  head_class = class_mem;
            op_b_store: begin
                head_class = class_mem;
                head_rd    = '0;
            end
            op_b_reg: begin
                if (iq.head_inst[31:25] == 7'd1) begin    // M extension
                    head_class = iq.head_inst[14] ? class_div : class_mul;
                end else begin
                    head_class = class_add;
                end
            end
            op_b_imm, op_b_lui, op_b_auipc: head_class = class_add;
            default: head_class = class_none;
        endcase
    end

    // output slot free, or emptied on this edge
    assign iq.pop = !iq.empty && !flush_i && (!valid_q || dispatch_ready_i);

    assign dispatch_valid_o = valid_q;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            valid_q <= 1'b0;
        end else if (iq.pop) begin
            valid_q <= 1'b1;
        end else if (dispatch_ready_i) begin
            valid_q <= 1'b0;                // taken, nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (iq.pop) begin
            dispatch_pc_o    <= iq.head_pc;
            dispatch_inst_o  <= iq.head_inst;
            dispatch_class_o <= head_class;
            dispatch_rd_o    <= head_rd;
            dispatch_rs1_o   <= iq.head_inst[19:15];
            dispatch_rs2_o   <= iq.head_inst[24:20];
        end
    end

endmodule : dispatch_decode

// File: rtl/frontend_top.sv
`timescale 1ns/10ps

module frontend_top
import frontend_pkg::*;
#(
    parameter addr_t       RESET_PC = 32'h1eceb000,
    parameter int unsigned IQ_DEPTH = 16
)
(
    input   logic           clk,
    input   logic           rst,

    input   logic           redirect_i,
    input   addr_t          redirect_pc_i,

    output  addr_t          bmem_addr_o,
    output  logic           bmem_read_o,
    input   logic           bmem_ready_i,
    input   addr_t          bmem_raddr_i,
    input   beat_t          bmem_rdata_i,
    input   logic           bmem_rvalid_i,

    output  logic           dispatch_valid_o,
    input   logic           dispatch_ready_i,
    output  addr_t          dispatch_pc_o,
    output  inst_t          dispatch_inst_o,
    output  inst_class_e    dispatch_class_o,
    output  arch_reg_t      dispatch_rd_o,
    output  arch_reg_t      dispatch_rs1_o,
    output  arch_reg_t      dispatch_rs2_o
);

    iq_push_if push_bus ();     // fetch -> queue
    iq_pop_if  pop_bus ();      // queue -> dispatch

    line_fetch #(
        .RESET_PC       (RESET_PC)
    ) line_fetch_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_i     (redirect_i),
        .redirect_pc_i  (redirect_pc_i),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_raddr_i   (bmem_raddr_i),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_rvalid_i  (bmem_rvalid_i),
        .iq             (push_bus.producer)
    );

    inst_queue #(
        .IQ_DEPTH       (IQ_DEPTH)
    ) inst_queue_i (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (redirect_i),   // redirect empties the queue
        .wr             (push_bus.buffer_in),
        .rd             (pop_bus.buffer_out)
    );

    dispatch_decode dispatch_decode_i (
        .clk              (clk),
        .rst              (rst),
        .flush_i          (redirect_i),
        .iq               (pop_bus.consumer),
        .dispatch_valid_o (dispatch_valid_o),
        .dispatch_ready_i (dispatch_ready_i),
        .dispatch_pc_o    (dispatch_pc_o),
        .dispatch_inst_o  (dispatch_inst_o),
        .dispatch_class_o (dispatch_class_o),
        .dispatch_rd_o    (dispatch_rd_o),
        .dispatch_rs1_o   (dispatch_rs1_o),
        .dispatch_rs2_o   (dispatch_rs2_o)
    );

endmodule : frontend_top

// File: tests/frontend_assert.sv
`timescale 1ns/10ps

module frontend_assert
import frontend_pkg::*;
(
    input   logic           clk,
    input   logic           rst,
    input   logic           redirect_i,
    input   logic           bmem_read_i,
    input   logic           bmem_ready_i,
    input   addr_t          bmem_addr_i,
    input   logic           push_i,
    input   logic           full_i,
    input   logic           pop_i,
    input   logic           empty_i,
    input   logic           dispatch_valid_i,
    input   logic           dispatch_ready_i,
    input   addr_t          dispatch_pc_i,
    input   inst_t          dispatch_inst_i,
    input   inst_class_e    dispatch_class_i
);

    int unsigned fail_count = 0;    // assertion failures so far

    read_pulse: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |=> !bmem_read_i)
        else begin
            fail_count++;
            $error("bmem_read_o longer than one cycle");
        end

    read_legal: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_ready_i && bmem_addr_i[LINE_OFFSET_BITS-1:0] == '0)
        else begin
            fail_count++;
            $error("read without ready or unaligned");
        end

    push_room: assert property (@(posedge clk) disable iff (rst) push_i |-> !full_i)
        else begin
            fail_count++;
            $error("push into a full queue");
        end

    pop_data: assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_i)
        else begin
            fail_count++;
            $error("pop from an empty queue");
        end

    // held item must not move until taken
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid_i && !dispatch_ready_i && !redirect_i |=>
        dispatch_valid_i && $stable(dispatch_pc_i) && $stable(dispatch_inst_i) &&
        $stable(dispatch_class_i))
        else begin
            fail_count++;
            $error("dispatch output changed while stalled");
        end

endmodule : frontend_assert

bind frontend_top frontend_assert assert_i (
    .clk              (clk),
    .rst              (rst),
    .redirect_i       (redirect_i),
    .bmem_read_i      (bmem_read_o),
    .bmem_ready_i     (bmem_ready_i),
    .bmem_addr_i      (bmem_addr_o),
    .push_i           (push_bus.push),
    .full_i           (push_bus.full),
    .pop_i            (pop_bus.pop),
    .empty_i          (pop_bus.empty),
    .dispatch_valid_i (dispatch_valid_o),
    .dispatch_ready_i (dispatch_ready_i),
    .dispatch_pc_i    (dispatch_pc_o),
    .dispatch_inst_i  (dispatch_inst_o),
    .dispatch_class_i (dispatch_class_o)
);

// File: tests/frontend_tb.sv
`timescale 1ns/10ps

module frontend_tb
import frontend_pkg::*;
();

    localparam addr_t RESET_PC       = 32'h1eceb000;
    localparam int    IQ_DEPTH       = 16;
    localparam int    MEM_WORDS      = 1024;    // 4 KB, indexed by addr[11:2]
    localparam int    CLK_PERIOD     = 40;
    localparam int    RESET_CYCLES   = 10;
    localparam int    SEQ_ITEMS      = 40;
    localparam int    CLASS_ITEMS    = 40;
    localparam int    FILL_CYCLES    = 120;
    localparam int    IDLE_CYCLES    = 60;
    localparam int    BP_ITEMS       = 40;
    localparam int    REDIRECT_ITEMS = 12;
    localparam int    STALL_CYCLES   = 30;
    localparam int    SLOW_ITEMS     = 40;
    localparam int    TEST_LEN       = RESET_CYCLES + SEQ_ITEMS + CLASS_ITEMS + FILL_CYCLES +
                                       IDLE_CYCLES + BP_ITEMS + 2 * REDIRECT_ITEMS +
                                       STALL_CYCLES + SLOW_ITEMS;
    localparam int    WORST_BURST    = 2 + BEATS_PER_LINE * 8;  // slow gaps, request cycle
    localparam int    TIMEOUT_NS     = TEST_LEN * WORST_BURST * CLK_PERIOD;

    logic        clk;
    logic        rst;
    logic        redirect_i;
    addr_t       redirect_pc_i;
    addr_t       bmem_addr_o;
    logic        bmem_read_o;
    logic        bmem_ready_i;
    addr_t       bmem_raddr_i;
    beat_t       bmem_rdata_i;
    logic        bmem_rvalid_i;
    logic        dispatch_valid_o;
    logic        dispatch_ready_i;
    addr_t       dispatch_pc_o;
    inst_t       dispatch_inst_o;
    inst_class_e dispatch_class_o;
    arch_reg_t   dispatch_rd_o;
    arch_reg_t   dispatch_rs1_o;
    arch_reg_t   dispatch_rs2_o;

    inst_t       mem [MEM_WORDS];
    logic [31:0] lfsr = 32'ha5f4;
    string       test_name = "reset";
    addr_t       exp_pc = RESET_PC;
    int          taken = 0;         // items accepted at the dispatch port
    int          reads = 0;
    int          bursts = 0;
    logic        slow_mem = 1'b0;   // wider gaps between beats
    logic [5:0]  seen_class = '0;

    frontend_top #(
        .RESET_PC (RESET_PC),
        .IQ_DEPTH (IQ_DEPTH)
    ) uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic inst_t mem_word(input addr_t a);
        return mem[a[11:2]];
    endfunction

    // random legal encoding of one kind
    function automatic inst_t make_inst(input int idx);
        inst_t      w;
        logic [2:0] sel;
        w   = rand_bits(32);
        sel = 3'(rand_bits(3));
        if (idx < 8) begin
            sel = 3'(idx);          // first line holds one of each kind
        end
        case (sel)
            3'd0: w[6:0] = w[31] ? op_b_lui : (w[30] ? op_b_auipc : op_b_imm);
            3'd1: begin
                w[6:0]   = op_b_reg;
                w[31:25] = 7'h00;
            end
            3'd2, 3'd3: begin
                w[6:0]   = op_b_reg;
                w[31:25] = 7'h01;   // mul/div group
                w[14]    = sel[0];
            end
            3'd4: w[6:0] = op_b_load;
            3'd5: w[6:0] = op_b_store;
            3'd6: w[6:0] = w[31] ? op_b_jal : (w[30] ? op_b_jalr : op_b_br);
            default: w[6:0] = 7'b0001111;  // fence
        endcase
        return w;
    endfunction

    function automatic inst_class_e ref_class(input inst_t w);
        logic [6:0] op;
        op = w[6:0];
        if (op == op_b_jal || op == op_b_jalr || op == op_b_br) return class_br;
        if (op == op_b_load || op == op_b_store) return class_mem;
        if (op == op_b_reg && w[31:25] == 7'd1) return w[14] ? class_div : class_mul;
        if (op == op_b_reg || op == op_b_imm || op == op_b_lui || op == op_b_auipc) begin
            return class_add;
        end
        return class_none;
    endfunction

    function automatic arch_reg_t ref_rd(input inst_t w);
        return (w[6:0] == op_b_br || w[6:0] == op_b_store) ? 5'd0 : w[11:7];
    endfunction

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("ERROR %s: pc expected %h actual %h", name, exp, act);
            stop_on_failure("pc mismatch");
        end
    endtask

    task automatic check_inst(input string name, input inst_t exp, input inst_t act);
        if (exp !== act) begin
            $display("ERROR %s: inst expected %h actual %h", name, exp, act);
            stop_on_failure("instruction mismatch");
        end
    endtask

    task automatic check_class(input string name, input inst_class_e exp,
                               input inst_class_e act);
        if (exp !== act) begin
            $display("ERROR %s: class expected %s actual %s", name, exp.name(), act.name());
            stop_on_failure("class mismatch");
        end
    endtask

    task automatic check_reg(input string name, input arch_reg_t exp, input arch_reg_t act);
        if (exp !== act) begin
            $display("ERROR %s: reg expected %0d actual %0d", name, exp, act);
            stop_on_failure("register field mismatch");
        end
    endtask

    // every accepted item is compared against the memory word at the expected pc
    always @(negedge clk) begin : dispatch_monitor
        inst_t w;
        if (!rst && dispatch_valid_o && dispatch_ready_i) begin
            w = mem_word(exp_pc);
            check_addr(test_name, exp_pc, dispatch_pc_o);
            check_inst(test_name, w, dispatch_inst_o);
            check_class(test_name, ref_class(w), dispatch_class_o);
            check_reg(test_name, ref_rd(w), dispatch_rd_o);
            check_reg(test_name, w[19:15], dispatch_rs1_o);
            check_reg(test_name, w[24:20], dispatch_rs2_o);
            seen_class[dispatch_class_o] = 1'b1;
            exp_pc = exp_pc + 32'd4;
            taken  = taken + 1;
        end
        if (redirect_i) begin
            exp_pc = redirect_pc_i;     // fetch restarts here
        end
    end

    // four beats per read, lfsr start delay and gaps
    always begin : burst_memory
        addr_t line;
        @(negedge clk);
        if (bmem_read_o) begin
            line  = bmem_addr_o;
            reads = reads + 1;
            @(posedge clk);
            #2;
            for (int b = 0; b < BEATS_PER_LINE; b++) begin
                bmem_rvalid_i = 1'b0;
                repeat (int'(rand_bits(slow_mem ? 3 : 1))) begin
                    @(posedge clk);
                    #2;
                end
                bmem_rvalid_i = 1'b1;
                bmem_raddr_i  = line;
                bmem_rdata_i  = {mem_word(line + 32'(8 * b + 4)), mem_word(line + 32'(8 * b))};
                @(posedge clk);
                #2;
            end
            bmem_rvalid_i = 1'b0;
            bursts = bursts + 1;        // line now draining
        end
    end

    task automatic wait_taken(input int n);
        int target;
        target = taken + n;
        wait (taken >= target);
        @(posedge clk);
        #2;
    endtask

    task automatic pulse_redirect(input addr_t target);
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        @(posedge clk);
        #2;
        redirect_i = 1'b0;
    endtask

    task automatic run_sequential();
        test_name        = "sequential";
        dispatch_ready_i = 1'b1;
        wait_taken(SEQ_ITEMS);
    endtask

    task automatic run_classes();
        test_name = "classes";
        wait_taken(CLASS_ITEMS);
        if (seen_class != 6'h3f) begin
            stop_on_failure("not every instruction class was dispatched");
        end
    endtask

    task automatic run_backpressure();
        int n;
        test_name        = "backpressure";
        dispatch_ready_i = 1'b0;
        repeat (FILL_CYCLES) @(posedge clk);
        n = reads;
        repeat (IDLE_CYCLES) @(posedge clk);
        if (reads != n) begin
            stop_on_failure("burst requested while the queue and line were full");
        end
        #2;
        dispatch_ready_i = 1'b1;
        wait_taken(BP_ITEMS);
    endtask

    task automatic run_redirect();
        int n;
        test_name = "redirect";
        n = reads;
        wait (reads != n);
        @(posedge clk);
        #2;
        pulse_redirect(RESET_PC + 32'h214);     // mid-line, burst in flight
        wait_taken(REDIRECT_ITEMS);
        @(negedge clk);
        n = bursts;
        wait (bursts != n);
        pulse_redirect(RESET_PC + 32'h3a8);     // during the drain
        wait_taken(REDIRECT_ITEMS);
    endtask

    task automatic run_slow_memory();
        test_name    = "slow_memory";
        slow_mem     = 1'b1;
        bmem_ready_i = 1'b0;
        repeat (STALL_CYCLES) @(posedge clk);
        #2;
        bmem_ready_i = 1'b1;
        wait_taken(SLOW_ITEMS);
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        redirect_i       = 1'b0;
        redirect_pc_i    = '0;
        bmem_ready_i     = 1'b1;
        bmem_raddr_i     = '0;
        bmem_rdata_i     = '0;
        bmem_rvalid_i    = 1'b0;
        dispatch_ready_i = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = make_inst(i);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        if (bmem_read_o !== 1'b0 || dispatch_valid_o !== 1'b0) begin
            stop_on_failure("outputs not idle after reset");
        end
        @(posedge clk);
        #2;

        run_sequential();
        run_classes();
        run_backpressure();
        run_redirect();
        run_slow_memory();

        if (uut.assert_i.fail_count != 0) begin
            stop_on_failure("a concurrent assertion failed");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule : frontend_tb

// File: verilog.f
rtl/frontend_pkg.sv
rtl/iq_push_if.sv
rtl/iq_pop_if.sv
rtl/line_fetch.sv
rtl/inst_queue.sv
rtl/dispatch_decode.sv
rtl/frontend_top.sv
tests/frontend_assert.sv
tests/frontend_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := frontend_tb
RTL_TOP    := frontend_top
FILELIST   := verilog.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := test failed
PASS_MSG   := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
